//--- rvMemPkg.sv
package rvMemPkg;

	// widths of the memory stage datapath
	localparam int addrWidth = 32; // byte address, one full word
	localparam int dataWidth = 32; // load and store data word
	localparam int func3Width = 3; // func3 field of the load or store
	localparam int ramIndexWidth = 10; // word index, address bits 11 down to 2
	localparam int ramDepth = 1024; // words held in the data RAM
	localparam int laneCount = dataWidth / 8; // byte lanes per word

	// payload types
	typedef logic [dataWidth-1:0] memWord; // one data word
	typedef logic [addrWidth-1:0] addrWord; // one byte address
	typedef logic [func3Width-1:0] func3Code; // raw func3 field
	typedef logic [laneCount-1:0] byteMask; // bit 0 enables bits 7 to 0

	// RV32I func3 encodings, the same for loads and stores
	localparam func3Code lsByte = 3'd0; // lb and sb
	localparam func3Code lsHalf = 3'd1; // lh and sh
	localparam func3Code lsWord = 3'd2; // lw and sw
	localparam func3Code ldByteU = 3'd4; // lbu, load only
	localparam func3Code ldHalfU = 3'd5; // lhu, load only

endpackage

//--- storeAlign.sv
`timescale 1ns/1ps

module storeAlign (
	input	rvMemPkg::addrWord	memAddr, // byte address of the store
	input	rvMemPkg::func3Code	func3, // sb, sh or sw
	input	rvMemPkg::memWord	memWriteData, // store data, low bits for sb and sh
	output	rvMemPkg::memWord	laneData, // data moved into its byte lanes
	output	rvMemPkg::byteMask	laneMask, // per-lane write enables
	output	logic	storeBad // misaligned or undefined store
);
	import rvMemPkg::*;

	logic [1:0] byteOffset; // byte position inside the word
	logic [4:0] laneShift; // offset in bits
	memWord bytePlaced; // low byte copied into all lanes
	memWord halfPlaced; // halfword shifted up to its lanes
	logic halfFits; // halfword stays inside one word

	assign byteOffset = memAddr[1:0];
	assign laneShift = {byteOffset, 3'b000}; // offset times eight
	assign bytePlaced = {laneCount{memWriteData[7:0]}}; // mask picks the live lane
	assign halfPlaced = {{(dataWidth-16){1'b0}}, memWriteData[15:0]} << laneShift;
	assign halfFits = (byteOffset != 2'd3); // offset 3 would cross into next word

	always_comb
	begin
		laneData = memWriteData; // don't care while mask is empty
		laneMask = '0; // nothing written by default
		storeBad = 1'b0;
		case (func3)
			lsByte:
			begin
				laneData = bytePlaced;
				laneMask = byteMask'(4'b0001 << byteOffset); // one lane at any offset
			end
			lsHalf:
			begin
				if (halfFits)
				begin
					laneData = halfPlaced;
					laneMask = byteMask'(4'b0011 << byteOffset); // lanes 0-1, 1-2 or 2-3
				end
				else
				begin
					storeBad = 1'b1; // sh at offset 3
				end
			end
			lsWord:
			begin
				if (byteOffset == 2'd0)
				begin
					laneData = memWriteData; // whole word as given
					laneMask = '1;
				end
				else
				begin
					storeBad = 1'b1; // sw must be word aligned
				end
			end
			default:
			begin
				storeBad = 1'b1; // lbu, lhu and undefined codes are no stores
			end
		endcase
	end

endmodule

//--- dataRam.sv
`timescale 1ns/1ps

module dataRam (
	input	logic	clk,
	input	logic	rstN, // writes blocked while low
	input	logic [rvMemPkg::ramIndexWidth-1:0]	wordIndex, // word to read and write
	input	rvMemPkg::memWord	laneData, // write data, already in lanes
	input	rvMemPkg::byteMask	laneMask, // lanes to update
	input	logic	writeEnable, // store in this cycle
	output	rvMemPkg::memWord	ramWord // word at wordIndex
);
	import rvMemPkg::*;

	memWord ram [ramDepth]; // contents survive reset

	logic writeNow; // write qualified by reset

	assign writeNow = rstN && writeEnable;

	// byte-lane write at the rising edge
	always_ff @(posedge clk)
	begin
		if (writeNow)
		begin
			for (int lane = 0; lane < laneCount; lane++)
			begin
				if (laneMask[lane])
				begin
					ram[wordIndex][lane*8 +: 8] <= laneData[lane*8 +: 8]; // one lane
				end
			end
		end
	end

	// asynchronous read, old word shown during the write cycle
	assign ramWord = ram[wordIndex];

endmodule

//--- loadExtend.sv
`timescale 1ns/1ps

module loadExtend (
	input	logic [1:0]	byteOffset, // byte position inside the word
	input	rvMemPkg::func3Code	func3, // lb, lh, lw, lbu or lhu
	input	rvMemPkg::memWord	ramWord, // word read from the RAM
	output	rvMemPkg::memWord	memReadData, // extended load result
	output	logic	loadBad // misaligned or undefined load
);
	import rvMemPkg::*;

	logic [4:0] laneShift; // offset in bits
	memWord shifted; // addressed byte moved down to bit 0
	logic [7:0] selByte; // byte at the offset
	logic [15:0] selHalf; // halfword starting at the offset
	logic halfFits; // halfword stays inside one word
	logic wordAligned; // offset zero

	assign laneShift = {byteOffset, 3'b000};
	assign shifted = ramWord >> laneShift; // upper bits zero-filled
	assign selByte = shifted[7:0];
	assign selHalf = shifted[15:0];
	assign halfFits = (byteOffset != 2'd3);
	assign wordAligned = (byteOffset == 2'd0);

	always_comb
	begin
		memReadData = '0; // flagged loads read zero
		loadBad = 1'b0;
		case (func3)
			lsByte:
			begin
				memReadData = {{(dataWidth-8){selByte[7]}}, selByte}; // lb sign-extends
			end
			ldByteU:
			begin
				memReadData = {{(dataWidth-8){1'b0}}, selByte}; // lbu zero-fills
			end
			lsHalf:
			begin
				if (halfFits)
				begin
					memReadData = {{(dataWidth-16){selHalf[15]}}, selHalf}; // lh
				end
				else
				begin
					loadBad = 1'b1; // lh at offset 3
				end
			end
			ldHalfU:
			begin
				if (halfFits)
				begin
					memReadData = {{(dataWidth-16){1'b0}}, selHalf}; // lhu
				end
				else
				begin
					loadBad = 1'b1; // lhu at offset 3
				end
			end
			lsWord:
			begin
				if (wordAligned)
				begin
					memReadData = ramWord; // lw passes the word as stored
				end
				else
				begin
					loadBad = 1'b1;
				end
			end
			default:
			begin
				loadBad = 1'b1; // codes 3, 6 and 7 are undefined
			end
		endcase
	end

endmodule

//--- dataMem.sv
`timescale 1ns/1ps

module dataMem (
	input	logic	clk,
	input	logic	rstN, // sync, active low
	input	rvMemPkg::addrWord	memAddr, // effective byte address
	input	logic	memWriteEnable, // high for stores
	input	rvMemPkg::memWord	memWriteData, // store data from the register file
	input	rvMemPkg::func3Code	func3, // access size and signedness
	output	rvMemPkg::memWord	memReadData, // load result, same cycle
	output	logic	memMisaligned // access was flagged
);
	import rvMemPkg::*;

	logic [ramIndexWidth-1:0] wordIndex; // address bits 11 to 2
	logic [1:0] byteOffset; // address bits 1 to 0
	memWord laneData; // store data in lanes
	byteMask laneMask; // lanes the store touches
	logic storeBad; // flag from the store side
	logic loadBad; // flag from the load side
	logic ramWrite; // store that may land
	memWord ramWord; // word at the addressed index

	assign wordIndex = memAddr[ramIndexWidth+1:2];
	assign byteOffset = memAddr[1:0];
	assign ramWrite = memWriteEnable && !storeBad; // flagged store writes nothing

	storeAlign uStoreAlign (
		.memAddr(memAddr),
		.func3(func3),
		.memWriteData(memWriteData),
		.laneData(laneData),
		.laneMask(laneMask),
		.storeBad(storeBad)
	);

	dataRam uDataRam (
		.clk(clk),
		.rstN(rstN),
		.wordIndex(wordIndex),
		.laneData(laneData),
		.laneMask(laneMask),
		.writeEnable(ramWrite),
		.ramWord(ramWord)
	);

	loadExtend uLoadExtend (
		.byteOffset(byteOffset),
		.func3(func3),
		.ramWord(ramWord),
		.memReadData(memReadData),
		.loadBad(loadBad)
	);

	// store flag during writes, load flag otherwise
	assign memMisaligned = memWriteEnable ? storeBad : loadBad;

endmodule

//--- tbDataMem.sv
`timescale 1ns/1ps

module tbDataMem;
	import rvMemPkg::*;

	localparam int clkPeriod = 8; // ns
	localparam int vecCount = 64; // lines in memVectors.txt
	localparam int vecFields = 6; // we, func3, addr, wdata, rdata, flag
	localparam int randomCount = 400;
	localparam int modelSize = 256; // bytes of the first 64 words
	localparam int watchdogCycles = (vecCount + randomCount + 20) * 2;

	logic clk;
	logic rstN;
	addrWord memAddr;
	logic memWriteEnable;
	memWord memWriteData;
	func3Code func3;
	memWord memReadData;
	logic memMisaligned;

	logic [31:0] vecMem [0:vecCount*vecFields-1]; // one token per entry
	logic [7:0] modelBytes [0:modelSize-1]; // reference byte array
	logic [31:0] lcgState;
	int wordErrors;
	int flagErrors;
	int otherErrors;

	dataMem UUT (
		.clk(clk),
		.rstN(rstN),
		.memAddr(memAddr),
		.memWriteEnable(memWriteEnable),
		.memWriteData(memWriteData),
		.func3(func3),
		.memReadData(memReadData),
		.memMisaligned(memMisaligned)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223; // numerical recipes constants
		return lcgState;
	endfunction

	function automatic memWord fillWord(input addrWord a);
		return (a * 32'h9e3779b1) ^ {a[15:0], ~a[15:0]}; // every address bit matters
	endfunction

	// expected load from the byte array, flag in bit 32
	function automatic logic [32:0] loadModel(input func3Code f3, input logic [7:0] a);
		logic [1:0] off;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [32:0] res;
		off = a[1:0];
		b0 = modelBytes[a];
		b1 = modelBytes[a + 8'd1]; // only used when the half fits
		res = {1'b1, 32'h0}; // flagged loads give zero
		case (f3)
			lsByte: res = {1'b0, {24{b0[7]}}, b0};
			ldByteU: res = {1'b0, 24'h0, b0};
			lsHalf: if (off != 2'd3) res = {1'b0, {16{b1[7]}}, b1, b0};
			ldHalfU: if (off != 2'd3) res = {1'b0, 16'h0, b1, b0};
			lsWord: if (off == 2'd0) res = {1'b0, modelBytes[a + 8'd3], modelBytes[a + 8'd2], b1, b0};
			default: res = {1'b1, 32'h0};
		endcase
		return res;
	endfunction

	// apply a store to the byte array, bad set when nothing may be written
	task automatic storeModel(input func3Code f3, input logic [7:0] a, input memWord wd,
		output logic bad);
		logic [1:0] off;
		off = a[1:0];
		bad = 1'b0;
		if (f3 == lsByte)
		begin
			modelBytes[a] = wd[7:0];
		end
		else if (f3 == lsHalf && off != 2'd3)
		begin
			modelBytes[a] = wd[7:0]; // low byte at the lower address
			modelBytes[a + 8'd1] = wd[15:8];
		end
		else if (f3 == lsWord && off == 2'd0)
		begin
			for (int k = 0; k < 4; k++)
			begin
				modelBytes[a + 8'(k)] = wd[k*8 +: 8];
			end
		end
		else
		begin
			bad = 1'b1;
		end
	endtask

	task automatic checkWord(input memWord expected, input memWord seen, input string what);
		if (seen !== expected)
		begin
			wordErrors++;
			$display("** Error at %0t: %s read data expected %h, seen %h", $time, what,
				expected, seen);
		end
	endtask

	task automatic checkFlag(input logic expected, input logic seen, input string what);
		if (seen !== expected)
		begin
			flagErrors++;
			$display("** Error at %0t: %s misaligned flag expected %b, seen %b", $time, what,
				expected, seen);
		end
	endtask

	// drive 1 ns after the edge, return 1 ns before the next one
	task automatic applyAccess(input logic we, input func3Code f3, input addrWord addr,
		input memWord wd);
		@(posedge clk);
		#1;
		memWriteEnable = we;
		func3 = f3;
		memAddr = addr;
		memWriteData = wd;
		#(clkPeriod - 2);
	endtask

	task automatic replayVectors();
		logic we;
		memWord expData;
		logic expFlag;
		for (int i = 0; i < vecCount; i++)
		begin
			we = vecMem[i*vecFields][0];
			expData = vecMem[i*vecFields+4];
			expFlag = vecMem[i*vecFields+5][0];
			applyAccess(we, vecMem[i*vecFields+1][2:0], vecMem[i*vecFields+2],
				vecMem[i*vecFields+3]);
			checkFlag(expFlag, memMisaligned, $sformatf("vector %0d", i));
			if (!we)
			begin
				checkWord(expData, memReadData, $sformatf("vector %0d", i)); // loads only
			end
		end
	endtask

	task automatic resetWriteCheck();
		applyAccess(1'b1, lsWord, 32'h100, 32'h600dcafe); // lands at the next edge
		checkFlag(1'b0, memMisaligned, "store before reset");
		@(posedge clk);
		#1;
		rstN = 1'b0; // store stays on the bus through reset
		memWriteData = 32'hbad0bad0;
		repeat (3) @(posedge clk);
		#1;
		rstN = 1'b1;
		memWriteEnable = 1'b0;
		#(clkPeriod - 2);
		checkWord(32'h600dcafe, memReadData, "load after reset");
		checkFlag(1'b0, memMisaligned, "load after reset");
	endtask

	task automatic randomPhase();
		logic [31:0] r;
		memWord wd;
		logic [7:0] a;
		logic [32:0] expLoad;
		logic bad;
		for (int w = 0; w < modelSize / 4; w++)
		begin
			a = 8'(w * 4);
			applyAccess(1'b1, lsWord, addrWord'(a), fillWord(addrWord'(a)));
			checkFlag(1'b0, memMisaligned, "preload store");
			storeModel(lsWord, a, fillWord(addrWord'(a)), bad);
		end
		for (int n = 0; n < randomCount; n++)
		begin
			r = nextRandom();
			wd = nextRandom();
			a = r[31:24]; // first 64 words only
			expLoad = loadModel(r[23:21], a); // old word, also valid in a store cycle
			applyAccess(r[20], r[23:21], addrWord'(a), wd);
			checkWord(expLoad[31:0], memReadData, $sformatf("random access %0d", n));
			if (r[20])
			begin
				storeModel(r[23:21], a, wd, bad);
				checkFlag(bad, memMisaligned, $sformatf("random store %0d", n));
			end
			else
			begin
				checkFlag(expLoad[32], memMisaligned, $sformatf("random load %0d", n));
			end
		end
	endtask

	initial
	begin
		logic vecOk;
		rstN = 1'b0;
		memAddr = '0;
		memWriteEnable = 1'b0;
		memWriteData = '0;
		func3 = lsWord;
		lcgState = 32'h55d4;
		wordErrors = 0;
		flagErrors = 0;
		otherErrors = 0;
		vecOk = 1'b1;
		$readmemh("memVectors.txt", vecMem);
		for (int k = 0; k < vecCount * vecFields; k++)
		begin
			if ($isunknown(vecMem[k]))
			begin
				vecOk = 1'b0; // file missing or a line cut short
			end
		end
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;
		if (vecOk)
		begin
			replayVectors();
		end
		else
		begin
			otherErrors++;
			$display("vector file memVectors.txt is missing or holds fewer than %0d vectors",
				vecCount);
		end
		resetWriteCheck();
		randomPhase();
		$display("read data errors: %0d, flag errors: %0d, other errors: %0d", wordErrors,
			flagErrors, otherErrors);
		if (wordErrors + flagErrors + otherErrors == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
		$display("Errors found");
		$finish;
	end

endmodule

//--- memVectors.txt
// columns: writeEnable func3 address writeData expectedReadData expectedFlag (hex)
// expected read data is checked on loads only, store lines carry zero there
1 2 00000040 12345678 00000000 0
1 2 00000044 cafef00d 00000000 0
1 2 00000048 00000000 00000000 0
0 2 00000040 00000000 12345678 0
0 2 00000044 00000000 cafef00d 0
1 2 00000044 0badc0de 00000000 0
0 2 00000040 00000000 12345678 0
0 2 00000044 00000000 0badc0de 0
1 0 00000048 000000a1 00000000 0
0 2 00000048 00000000 000000a1 0
1 0 00000049 ffffffb2 00000000 0
0 2 00000048 00000000 0000b2a1 0
1 0 0000004a 00000003 00000000 0
0 2 00000048 00000000 0003b2a1 0
1 0 0000004b 123456f4 00000000 0
0 2 00000048 00000000 f403b2a1 0
0 0 00000048 00000000 ffffffa1 0
0 4 00000048 00000000 000000a1 0
0 0 00000049 00000000 ffffffb2 0
0 4 00000049 00000000 000000b2 0
0 0 0000004a 00000000 00000003 0
0 4 0000004a 00000000 00000003 0
0 0 0000004b 00000000 fffffff4 0
0 4 0000004b 00000000 000000f4 0
1 2 00000050 11223344 00000000 0
1 1 00000050 0000beef 00000000 0
0 2 00000050 00000000 1122beef 0
0 1 00000050 00000000 ffffbeef 0
0 5 00000050 00000000 0000beef 0
1 2 00000054 11223344 00000000 0
1 1 00000055 ffff8001 00000000 0
0 2 00000054 00000000 11800144 0
0 1 00000055 00000000 ffff8001 0
0 5 00000055 00000000 00008001 0
1 2 00000058 11223344 00000000 0
1 1 0000005a 00007abc 00000000 0
0 2 00000058 00000000 7abc3344 0
0 1 0000005a 00000000 00007abc 0
0 5 0000005a 00000000 00007abc 0
0 1 00000058 00000000 00003344 0
0 1 00000059 00000000 ffffbc33 0
1 1 0000005b 00001111 00000000 1
0 2 00000058 00000000 7abc3344 0
1 2 00000041 aaaaaaaa 00000000 1
1 2 00000042 aaaaaaaa 00000000 1
1 2 00000043 aaaaaaaa 00000000 1
0 2 00000040 00000000 12345678 0
0 2 00000041 00000000 00000000 1
0 2 00000042 00000000 00000000 1
0 2 00000043 00000000 00000000 1
0 1 0000005b 00000000 00000000 1
0 5 0000005b 00000000 00000000 1
0 3 00000040 00000000 00000000 1
0 6 00000040 00000000 00000000 1
0 7 00000040 00000000 00000000 1
1 3 00000040 55555555 00000000 1
1 4 00000040 55555555 00000000 1
1 5 00000040 55555555 00000000 1
1 6 00000040 55555555 00000000 1
1 7 00000040 55555555 00000000 1
0 2 00000040 00000000 12345678 0
1 2 00000ffc 89abcdef 00000000 0
0 2 00000ffc 00000000 89abcdef 0
0 2 00000040 00000000 12345678 0

//--- files.f
rvMemPkg.sv
storeAlign.sv
dataRam.sv
loadExtend.sv
dataMem.sv
tbDataMem.sv
